// ==== logic/wb_xbar_consts.svh ====
`ifndef WB_XBAR_CONSTS_SVH
`define WB_XBAR_CONSTS_SVH

// Master address splits into region and slave offset
`define WB_ADR_W 28
`define WB_OFFSET_W 24
`define WB_REGION_W 4

`define WB_DAT_W 32
`define WB_SEL_W 4

// Regions 0 up to WB_N_SLAVES-1 are mapped to slaves
`define WB_N_SLAVES 3

// Read data for an unmapped region
`define WB_UNMAPPED_DATA {`WB_DAT_W{1'b1}}

`endif

// ==== logic/wb_xbar_pkg.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

package wb_xbar_pkg;

	typedef logic [`WB_DAT_W-1:0] wb_data_t;
	typedef logic [`WB_SEL_W-1:0] wb_sel_t;

	// One address word, read flat or as region above offset
	typedef union packed {
		logic [`WB_ADR_W-1:0] flat;
		struct packed {
			logic [`WB_REGION_W-1:0] region;
			logic [`WB_OFFSET_W-1:0] offset;
		} split;
	} wb_addr_u;

	// Two masters, so one bit
	typedef logic wb_master_idx_t;

endpackage

`default_nettype wire

// ==== logic/wb_if.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

interface wb_if;

	// Request
	logic cyc;
	logic stb;
	logic we;
	wb_xbar_pkg::wb_sel_t sel;
	wb_xbar_pkg::wb_data_t dat_w;
	logic [`WB_OFFSET_W-1:0] adr;

	// Response
	logic ack;
	logic stall;
	logic err;
	wb_xbar_pkg::wb_data_t dat_r;

	modport master (
		output cyc, stb, we, sel, dat_w, adr,
		input ack, stall, err, dat_r
	);

	modport slave (
		input cyc, stb, we, sel, dat_w, adr,
		output ack, stall, err, dat_r
	);

endinterface

`default_nettype wire

// ==== logic/wb_master_port.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_master_port (
	input wire wb_clk_i,
	input wire rst_n_i,

	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire wb_xbar_pkg::wb_sel_t sel_i,
	input wire wb_xbar_pkg::wb_data_t dat_i,
	input wire wb_xbar_pkg::wb_addr_u adr_i,
	output logic ack_o,
	output logic stall_o,
	output logic err_o,
	output wb_xbar_pkg::wb_data_t dat_o,

	wb_if.master s0_o,
	wb_if.master s1_o,
	wb_if.master s2_o
);

	logic [`WB_REGION_W-1:0] region;
	logic mapped;

	assign region = adr_i.split.region;
	assign mapped = region < `WB_REGION_W'(`WB_N_SLAVES);

	// Only the addressed arbiter sees cyc
	assign s0_o.cyc = cyc_i && region == `WB_REGION_W'(0);
	assign s1_o.cyc = cyc_i && region == `WB_REGION_W'(1);
	assign s2_o.cyc = cyc_i && region == `WB_REGION_W'(2);

	assign s0_o.stb = stb_i;
	assign s0_o.we = we_i;
	assign s0_o.sel = sel_i;
	assign s0_o.dat_w = dat_i;
	assign s0_o.adr = adr_i.split.offset;

	assign s1_o.stb = stb_i;
	assign s1_o.we = we_i;
	assign s1_o.sel = sel_i;
	assign s1_o.dat_w = dat_i;
	assign s1_o.adr = adr_i.split.offset;

	assign s2_o.stb = stb_i;
	assign s2_o.we = we_i;
	assign s2_o.sel = sel_i;
	assign s2_o.dat_w = dat_i;
	assign s2_o.adr = adr_i.split.offset;

	// Unmapped region answers itself in the same cycle
	always_comb begin
		ack_o = cyc_i;
		stall_o = 1'b0;
		err_o = 1'b0;
		dat_o = `WB_UNMAPPED_DATA;
		if (mapped) begin
			case (region)
				`WB_REGION_W'(0): begin
					ack_o = s0_o.ack;
					stall_o = s0_o.stall;
					err_o = s0_o.err;
					dat_o = s0_o.dat_r;
				end
				`WB_REGION_W'(1): begin
					ack_o = s1_o.ack;
					stall_o = s1_o.stall;
					err_o = s1_o.err;
					dat_o = s1_o.dat_r;
				end
				default: begin
					ack_o = s2_o.ack;
					stall_o = s2_o.stall;
					err_o = s2_o.err;
					dat_o = s2_o.dat_r;
				end
			endcase
		end
	end

	// Slave side never acks a master that has dropped its cycle
	ack_needs_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		ack_o |-> cyc_i);

endmodule

`default_nettype wire

// ==== logic/wb_slave_arbiter.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_slave_arbiter (
	input wire wb_clk_i,
	input wire rst_n_i,

	wb_if.slave m0_i,
	wb_if.slave m1_i,

	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output wb_xbar_pkg::wb_sel_t sel_o,
	output wb_xbar_pkg::wb_data_t dat_o,
	output logic [`WB_OFFSET_W-1:0] adr_o,
	input wire ack_i,
	input wire stall_i,
	input wire err_i,
	input wire wb_xbar_pkg::wb_data_t dat_i
);

	logic grant_vld;
	wb_xbar_pkg::wb_master_idx_t grant;
	logic owner_cyc;
	logic own0;
	logic own1;

	assign own0 = grant_vld && grant == 1'b0;
	assign own1 = grant_vld && grant == 1'b1;
	assign owner_cyc = grant ? m1_i.cyc : m0_i.cyc;

	// Grant held while the owner keeps cyc up
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			grant_vld <= 1'b0;
			grant <= 1'b0;
		end else if (!grant_vld || !owner_cyc) begin
			// Lowest requesting master wins
			if (m0_i.cyc) begin
				grant_vld <= 1'b1;
				grant <= 1'b0;
			end else if (m1_i.cyc) begin
				grant_vld <= 1'b1;
				grant <= 1'b1;
			end else begin
				grant_vld <= 1'b0;
			end
		end
	end

	assign cyc_o = grant_vld && owner_cyc;
	assign stb_o = cyc_o && (grant ? m1_i.stb : m0_i.stb);
	assign we_o = grant ? m1_i.we : m0_i.we;
	assign sel_o = grant ? m1_i.sel : m0_i.sel;
	assign dat_o = grant ? m1_i.dat_w : m0_i.dat_w;
	assign adr_o = grant ? m1_i.adr : m0_i.adr;

	// Waiting masters see stall until granted
	assign m0_i.ack = own0 && ack_i;
	assign m0_i.err = own0 && err_i;
	assign m0_i.stall = own0 ? stall_i : 1'b1;
	assign m0_i.dat_r = dat_i;

	assign m1_i.ack = own1 && ack_i;
	assign m1_i.err = own1 && err_i;
	assign m1_i.stall = own1 ? stall_i : 1'b1;
	assign m1_i.dat_r = dat_i;

	// Slave cycle only for a master that requested on the edge before
	cyc_needs_grant: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		cyc_o |-> (grant ? $past(m1_i.cyc) : $past(m0_i.cyc)));

	// Slave ack only reaches the master whose cycle is at the slave
	no_stray_ack: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(!m0_i.ack || (cyc_o && !grant)) && (!m1_i.ack || (cyc_o && grant)));

endmodule

`default_nettype wire

// ==== logic/wb_interconnect_top.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_interconnect_top (
	input wire wb_clk_i,
	input wire rst_n_i,

	// Master 0
	input wire m0_cyc_i, m0_stb_i, m0_we_i,
	input wire [`WB_SEL_W-1:0] m0_sel_i,
	input wire [`WB_DAT_W-1:0] m0_dat_i,
	input wire [`WB_ADR_W-1:0] m0_adr_i,
	output wire m0_ack_o, m0_stall_o, m0_err_o,
	output wire [`WB_DAT_W-1:0] m0_dat_o,

	// Master 1
	input wire m1_cyc_i, m1_stb_i, m1_we_i,
	input wire [`WB_SEL_W-1:0] m1_sel_i,
	input wire [`WB_DAT_W-1:0] m1_dat_i,
	input wire [`WB_ADR_W-1:0] m1_adr_i,
	output wire m1_ack_o, m1_stall_o, m1_err_o,
	output wire [`WB_DAT_W-1:0] m1_dat_o,

	// Slave 0
	output wire s0_cyc_o, s0_stb_o, s0_we_o,
	output wire [`WB_SEL_W-1:0] s0_sel_o,
	output wire [`WB_DAT_W-1:0] s0_dat_o,
	output wire [`WB_OFFSET_W-1:0] s0_adr_o,
	input wire s0_ack_i, s0_stall_i, s0_err_i,
	input wire [`WB_DAT_W-1:0] s0_dat_i,

	// Slave 1
	output wire s1_cyc_o, s1_stb_o, s1_we_o,
	output wire [`WB_SEL_W-1:0] s1_sel_o,
	output wire [`WB_DAT_W-1:0] s1_dat_o,
	output wire [`WB_OFFSET_W-1:0] s1_adr_o,
	input wire s1_ack_i, s1_stall_i, s1_err_i,
	input wire [`WB_DAT_W-1:0] s1_dat_i,

	// Slave 2
	output wire s2_cyc_o, s2_stb_o, s2_we_o,
	output wire [`WB_SEL_W-1:0] s2_sel_o,
	output wire [`WB_DAT_W-1:0] s2_dat_o,
	output wire [`WB_OFFSET_W-1:0] s2_adr_o,
	input wire s2_ack_i, s2_stall_i, s2_err_i,
	input wire [`WB_DAT_W-1:0] s2_dat_i
);

	// One link per master and slave pair
	wb_if bus_m0_s0 ();
	wb_if bus_m0_s1 ();
	wb_if bus_m0_s2 ();
	wb_if bus_m1_s0 ();
	wb_if bus_m1_s1 ();
	wb_if bus_m1_s2 ();

	wb_master_port u_mport0 (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.cyc_i(m0_cyc_i), .stb_i(m0_stb_i), .we_i(m0_we_i),
		.sel_i(m0_sel_i), .dat_i(m0_dat_i), .adr_i(m0_adr_i),
		.ack_o(m0_ack_o), .stall_o(m0_stall_o), .err_o(m0_err_o), .dat_o(m0_dat_o),
		.s0_o(bus_m0_s0), .s1_o(bus_m0_s1), .s2_o(bus_m0_s2)
	);

	wb_master_port u_mport1 (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.cyc_i(m1_cyc_i), .stb_i(m1_stb_i), .we_i(m1_we_i),
		.sel_i(m1_sel_i), .dat_i(m1_dat_i), .adr_i(m1_adr_i),
		.ack_o(m1_ack_o), .stall_o(m1_stall_o), .err_o(m1_err_o), .dat_o(m1_dat_o),
		.s0_o(bus_m1_s0), .s1_o(bus_m1_s1), .s2_o(bus_m1_s2)
	);

	wb_slave_arbiter u_arb0 (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.m0_i(bus_m0_s0), .m1_i(bus_m1_s0),
		.cyc_o(s0_cyc_o), .stb_o(s0_stb_o), .we_o(s0_we_o),
		.sel_o(s0_sel_o), .dat_o(s0_dat_o), .adr_o(s0_adr_o),
		.ack_i(s0_ack_i), .stall_i(s0_stall_i), .err_i(s0_err_i), .dat_i(s0_dat_i)
	);

	wb_slave_arbiter u_arb1 (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.m0_i(bus_m0_s1), .m1_i(bus_m1_s1),
		.cyc_o(s1_cyc_o), .stb_o(s1_stb_o), .we_o(s1_we_o),
		.sel_o(s1_sel_o), .dat_o(s1_dat_o), .adr_o(s1_adr_o),
		.ack_i(s1_ack_i), .stall_i(s1_stall_i), .err_i(s1_err_i), .dat_i(s1_dat_i)
	);

	wb_slave_arbiter u_arb2 (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.m0_i(bus_m0_s2), .m1_i(bus_m1_s2),
		.cyc_o(s2_cyc_o), .stb_o(s2_stb_o), .we_o(s2_we_o),
		.sel_o(s2_sel_o), .dat_o(s2_dat_o), .adr_o(s2_adr_o),
		.ack_i(s2_ack_i), .stall_i(s2_stall_i), .err_i(s2_err_i), .dat_i(s2_dat_i)
	);

endmodule

`default_nettype wire

// ==== tests/tb_wb_slave_model.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

module tb_wb_slave_model (
	input wire wb_clk_i,
	input wire rst_n_i,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire wb_xbar_pkg::wb_sel_t sel_i,
	input wire wb_xbar_pkg::wb_data_t dat_i,
	input wire [`WB_OFFSET_W-1:0] adr_i,
	output logic ack_o,
	output logic stall_o,
	output logic err_o,
	output wb_xbar_pkg::wb_data_t dat_o
);

	wb_xbar_pkg::wb_data_t mem [16];

	assign stall_o = 1'b0;
	assign err_o = 1'b0;

	// Ack one cycle after each accepted transfer
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			dat_o <= '0;
			for (int i = 0; i < 16; i++) begin
				mem[i] <= '0;
			end
		end else begin
			ack_o <= cyc_i && stb_i;
			if (cyc_i && stb_i) begin
				dat_o <= mem[adr_i[3:0]];
				for (int b = 0; b < `WB_SEL_W; b++) begin
					if (we_i && sel_i[b])
						mem[adr_i[3:0]][b*8 +: 8] <= dat_i[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_wb_interconnect.sv ====
`default_nettype none

`include "wb_xbar_consts.svh"

module tb_wb_interconnect;

	// About 60 accesses of at most 6 cycles, plus reset, doubled
	localparam int CYCLE_LIMIT = 2 * (60 * 6 + 10);

	logic wb_clk_i;
	logic rst_n_i;
	logic [1:0] m_cyc, m_stb, m_we;
	logic [1:0][`WB_SEL_W-1:0] m_sel;
	logic [1:0][`WB_DAT_W-1:0] m_wdat;
	logic [1:0][`WB_ADR_W-1:0] m_adr;
	wire [1:0] m_ack, m_stall, m_err;
	wire [1:0][`WB_DAT_W-1:0] m_rdat;
	wire [2:0] s_cyc, s_stb, s_we, s_ack, s_stall, s_err;
	wire [2:0][`WB_SEL_W-1:0] s_sel;
	wire [2:0][`WB_DAT_W-1:0] s_wdat, s_rdat;
	wire [2:0][`WB_OFFSET_W-1:0] s_adr;

	int cycles;
	logic [31:0] lfsr_state;
	wb_xbar_pkg::wb_data_t shadow [3][16];
	string chk_name [$];
	bit chk_is_flag [$];
	wb_xbar_pkg::wb_data_t chk_exp [$];
	wb_xbar_pkg::wb_data_t chk_got [$];

	wb_interconnect_top u_dut (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.m0_cyc_i(m_cyc[0]), .m0_stb_i(m_stb[0]), .m0_we_i(m_we[0]),
		.m0_sel_i(m_sel[0]), .m0_dat_i(m_wdat[0]), .m0_adr_i(m_adr[0]),
		.m0_ack_o(m_ack[0]), .m0_stall_o(m_stall[0]), .m0_err_o(m_err[0]),
		.m0_dat_o(m_rdat[0]),
		.m1_cyc_i(m_cyc[1]), .m1_stb_i(m_stb[1]), .m1_we_i(m_we[1]),
		.m1_sel_i(m_sel[1]), .m1_dat_i(m_wdat[1]), .m1_adr_i(m_adr[1]),
		.m1_ack_o(m_ack[1]), .m1_stall_o(m_stall[1]), .m1_err_o(m_err[1]),
		.m1_dat_o(m_rdat[1]),
		.s0_cyc_o(s_cyc[0]), .s0_stb_o(s_stb[0]), .s0_we_o(s_we[0]),
		.s0_sel_o(s_sel[0]), .s0_dat_o(s_wdat[0]), .s0_adr_o(s_adr[0]),
		.s0_ack_i(s_ack[0]), .s0_stall_i(s_stall[0]), .s0_err_i(s_err[0]),
		.s0_dat_i(s_rdat[0]),
		.s1_cyc_o(s_cyc[1]), .s1_stb_o(s_stb[1]), .s1_we_o(s_we[1]),
		.s1_sel_o(s_sel[1]), .s1_dat_o(s_wdat[1]), .s1_adr_o(s_adr[1]),
		.s1_ack_i(s_ack[1]), .s1_stall_i(s_stall[1]), .s1_err_i(s_err[1]),
		.s1_dat_i(s_rdat[1]),
		.s2_cyc_o(s_cyc[2]), .s2_stb_o(s_stb[2]), .s2_we_o(s_we[2]),
		.s2_sel_o(s_sel[2]), .s2_dat_o(s_wdat[2]), .s2_adr_o(s_adr[2]),
		.s2_ack_i(s_ack[2]), .s2_stall_i(s_stall[2]), .s2_err_i(s_err[2]),
		.s2_dat_i(s_rdat[2])
	);

	for (genvar i = 0; i < 3; i++) begin : g_slave
		tb_wb_slave_model u_slave (
			.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
			.cyc_i(s_cyc[i]), .stb_i(s_stb[i]), .we_i(s_we[i]),
			.sel_i(s_sel[i]), .dat_i(s_wdat[i]), .adr_i(s_adr[i]),
			.ack_o(s_ack[i]), .stall_o(s_stall[i]), .err_o(s_err[i]),
			.dat_o(s_rdat[i])
		);
	end

	initial begin
		wb_clk_i = 1'b0;
		forever begin
			#4 wb_clk_i = ~wb_clk_i;
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge wb_clk_i);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
				$display("Test FAILED");
				$fatal(1);
			end
		end
	end

	// Galois LFSR stepped once per random bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'hB4BC_D35C;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Expected word after a write with byte enables
	function automatic wb_xbar_pkg::wb_data_t merge_write(wb_xbar_pkg::wb_data_t old_w,
			wb_xbar_pkg::wb_data_t new_w, wb_xbar_pkg::wb_sel_t sel);
		wb_xbar_pkg::wb_data_t res;
		res = old_w;
		for (int b = 0; b < `WB_SEL_W; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check_data(string name, wb_xbar_pkg::wb_data_t exp,
			wb_xbar_pkg::wb_data_t got);
		if (got !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic got);
		if (got !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, got);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic expect_val(string name, bit is_flag, wb_xbar_pkg::wb_data_t exp,
			wb_xbar_pkg::wb_data_t got);
		chk_name.push_back(name);
		chk_is_flag.push_back(is_flag);
		chk_exp.push_back(exp);
		chk_got.push_back(got);
	endtask

	initial begin
		string name;
		wb_xbar_pkg::wb_data_t exp;
		wb_xbar_pkg::wb_data_t got;
		forever begin
			@(posedge wb_clk_i);
			while (chk_name.size() > 0) begin
				name = chk_name.pop_front();
				exp = chk_exp.pop_front();
				got = chk_got.pop_front();
				if (chk_is_flag.pop_front())
					check_flag(name, exp[0], got[0]);
				else
					check_data(name, exp, got);
			end
		end
	end

	// One single transfer; waits out stall, then for ack or err
	task automatic access(input int m, input wb_xbar_pkg::wb_addr_u adr, input logic we,
			input wb_xbar_pkg::wb_sel_t sel, input wb_xbar_pkg::wb_data_t wdat,
			output wb_xbar_pkg::wb_data_t rdat, output logic err, output int done_cyc);
		@(negedge wb_clk_i);
		m_cyc[m] = 1'b1;
		m_stb[m] = 1'b1;
		m_we[m] = we;
		m_sel[m] = sel;
		m_wdat[m] = wdat;
		m_adr[m] = adr.flat;
		#2;
		while (m_stall[m]) begin
			@(negedge wb_clk_i);
			#2;
		end
		while (!m_ack[m] && !m_err[m]) begin
			@(negedge wb_clk_i);
			m_stb[m] = 1'b0;
			#2;
		end
		rdat = m_rdat[m];
		err = m_err[m];
		done_cyc = cycles;
		expect_val($sformatf("m%0d_stall", m), 1'b1, '0, {31'b0, m_stall[m]});
		@(negedge wb_clk_i);
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
	endtask

	task automatic write_word(int m, wb_xbar_pkg::wb_addr_u adr, wb_xbar_pkg::wb_sel_t sel,
			wb_xbar_pkg::wb_data_t wdat);
		wb_xbar_pkg::wb_data_t rdat;
		logic err;
		int t;
		access(m, adr, 1'b1, sel, wdat, rdat, err, t);
		expect_val($sformatf("m%0d_err", m), 1'b1, '0, {31'b0, err});
		shadow[adr.split.region][adr.split.offset[3:0]] =
			merge_write(shadow[adr.split.region][adr.split.offset[3:0]], wdat, sel);
	endtask

	task automatic read_check(int m, wb_xbar_pkg::wb_addr_u adr, output int t);
		wb_xbar_pkg::wb_data_t rdat;
		wb_xbar_pkg::wb_data_t exp;
		logic err;
		access(m, adr, 1'b0, '1, '0, rdat, err, t);
		if (adr.split.region < `WB_N_SLAVES)
			exp = shadow[adr.split.region][adr.split.offset[3:0]];
		else
			exp = `WB_UNMAPPED_DATA;
		expect_val($sformatf("m%0d_err", m), 1'b1, '0, {31'b0, err});
		expect_val($sformatf("m%0d_dat_o", m), 1'b0, exp, rdat);
	endtask

	task automatic rand_addr(int region, output wb_xbar_pkg::wb_addr_u adr);
		logic [31:0] v;
		v = rand_bits(`WB_OFFSET_W);
		adr.split.region = `WB_REGION_W'(region);
		adr.split.offset = v[`WB_OFFSET_W-1:0];
	endtask

	initial begin
		wb_xbar_pkg::wb_addr_u addrs [4];
		wb_xbar_pkg::wb_addr_u a0;
		wb_xbar_pkg::wb_addr_u a1;
		logic [31:0] v;
		int t0;
		int t1;
		lfsr_state = 32'd82;
		rst_n_i = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		m_sel = '0;
		m_wdat = '0;
		m_adr = '0;
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < 16; i++) begin
				shadow[r][i] = '0;
			end
		end
		repeat (5) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		rst_n_i = 1'b1;

		// Idle after reset
		@(negedge wb_clk_i);
		#2;
		for (int i = 0; i < 3; i++) begin
			expect_val($sformatf("s%0d_cyc_o", i), 1'b1, '0, {31'b0, s_cyc[i]});
		end
		expect_val("m0_ack_o", 1'b1, '0, {31'b0, m_ack[0]});
		expect_val("m1_ack_o", 1'b1, '0, {31'b0, m_ack[1]});

		// Random writes and read-back in every region
		for (int m = 0; m < 2; m++) begin
			for (int r = 0; r < 3; r++) begin
				for (int i = 0; i < 4; i++) begin
					rand_addr(r, addrs[i]);
					v = rand_bits(32);
					write_word(m, addrs[i], '1, v);
				end
				for (int i = 0; i < 4; i++) begin
					read_check(m, addrs[i], t0);
				end
			end
		end

		// Partial byte select
		rand_addr(1, a0);
		v = rand_bits(32);
		write_word(0, a0, 4'b0101, v);
		read_check(1, a0, t0);

		// Unmapped regions
		a0.split.region = 4'd5;
		read_check(0, a0, t0);
		a0.split.region = 4'd15;
		read_check(1, a0, t0);

		// Same slave from both masters on one edge
		rand_addr(2, a0);
		rand_addr(2, a1);
		fork
			read_check(0, a0, t0);
			read_check(1, a1, t1);
		join
		expect_val("m1_waited_for_m0", 1'b1, 32'd1, {31'b0, t1 > t0});

		// Different slaves in parallel
		rand_addr(0, a0);
		rand_addr(1, a1);
		v = rand_bits(32);
		fork
			write_word(0, a0, '1, v);
			write_word(1, a1, '1, ~v);
		join
		fork
			read_check(0, a0, t0);
			read_check(1, a1, t1);
		join

		while (chk_name.size() > 0) begin
			@(negedge wb_clk_i);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/wb_xbar_pkg.sv
logic/wb_if.sv
logic/wb_master_port.sv
logic/wb_slave_arbiter.sv
logic/wb_interconnect_top.sv
tests/tb_wb_slave_model.sv
tests/tb_wb_interconnect.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f compile.f --top-module tb_wb_interconnect -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_wb_interconnect > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
